/* bench/packet_patterns.txt */
# X hh n : expect a packet, header hh (hex), length n (decimal)
# V hh n : drive byte hh (hex) with din_valid high for n cycles
# I n    : drive n cycles with din_valid low
# W      : end of block, wait for the expected packets, then idle
# Basic framing, header plus three body bytes
X 42 4
V FF 1
V 42 1
V 01 1
V 02 1
V 03 1
W
# Noise with no delimiter gives no packet
V 12 1
V 34 1
I 2
V 56 3
V 00 1
W
# Noise dropped before a delimiter
X A5 3
V 77 1
V 00 2
V FF 1
V A5 1
V 01 2
W
# FF FF opens a packet with header FF, FF in the body is data
X FF 3
V FF 2
V 10 1
V FF 1
W
X 20 4
V FF 1
V 20 1
V FF 3
W
# Gap between delimiter and header
X 3C 3
V FF 1
I 6
V 3C 1
V 01 2
W
# Saturation at 255 and exactly 255
X 5A 255
V FF 1
V 5A 1
V 00 300
W
X 6B 255
V FF 1
V 6B 1
V 11 254
W
# Back-to-back packets with single gap cycles
X 11 2
X 33 3
X 55 1
V FF 1
V 11 1
V 22 1
I 1
V FF 1
V 33 1
V 44 2
I 1
V 9C 1
V FF 1
V 55 1
W

/* compile.f */
rtl/pkt_framer_pkg.sv
rtl/pkt_ctrl_if.sv
rtl/delim_detect.sv
rtl/pkt_framer_fsm.sv
rtl/pkt_capture.sv
rtl/packet_buffer_top.sv
bench/packet_buffer_props.sv
bench/tb_packet_buffer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the framer testbench with Verilator
# Must run from the project root, the testbench opens bench/ files

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_packet_buffer

rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_packet_buffer \
    -Mdir "$OBJ" -o "$BIN" \
    -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

# The testbench prints the fail message on any error
if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

/* bench/tb_packet_buffer.sv */
//------------------------------------------------------------
// Testbench for the byte-stream framer, file driven
// Run from the project root so the pattern path resolves
// Expect lines of a block must come before its stream lines
//------------------------------------------------------------
`timescale 1ns/1ns

module tb_packet_buffer import pkt_framer_pkg::*; ();

    localparam string PATTERN_FILE  = "bench/packet_patterns.txt";
    localparam int    DRAIN_TIMEOUT = 32;
    localparam int    SETTLE_CYCLES = 8;

    logic  clk;
    logic  rst_n;
    byte_t din;
    logic  din_valid;
    byte_t dout;
    len_t  pkt_len;
    logic  pkt_valid;

    // Expected packets in report order
    byte_t exp_hdr[$];
    len_t  exp_len[$];

    // Counters owned by the monitor
    int err_value;
    int err_pulse;
    int checked;
    // Counters owned by the stimulus thread
    int err_timeout;
    int err_file;
    int err_left;

    // Last reported values, must hold between pulses
    byte_t held_dout;
    len_t  held_len;
    byte_t hdr_e;
    len_t  len_e;

    packet_buffer_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .din       (din),
        .din_valid (din_valid),
        .dout      (dout),
        .pkt_len   (pkt_len),
        .pkt_valid (pkt_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------

    task automatic drive_byte(input byte_t value, input logic valid);
        @(posedge clk);
        din       <= value;
        din_valid <= valid;
    endtask

    // Random byte with valid low, the DUT must ignore it
    task automatic drive_idle();
        logic [31:0] noise;
        noise = $urandom;
        drive_byte(noise[7:0], 1'b0);
    endtask

    // Idle until every expected packet was reported
    task automatic drain_expected();
        int waited;
        waited = 0;
        while (exp_hdr.size() != 0 && waited < DRAIN_TIMEOUT) begin
            drive_idle();
            waited++;
        end
        if (exp_hdr.size() != 0) begin
            err_timeout++;
            $display("ERROR: no pkt_valid within %0d cycles, %0d packets outstanding",
                     DRAIN_TIMEOUT, exp_hdr.size());
            exp_hdr.delete();
            exp_len.delete();
        end
    endtask

    // One line of the pattern file
    task automatic run_command(input string cmd);
        logic [7:0]  code_c;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] rnd;
        int          n_args;
        int          idx;
        code_c = cmd[0];
        case (code_c)
            "X": begin
                n_args = $sscanf(cmd.substr(1, cmd.len() - 1), "%h %d", arg_a, arg_b);
                if (n_args == 2) begin
                    exp_hdr.push_back(arg_a[7:0]);
                    exp_len.push_back(arg_b[7:0]);
                end else begin
                    err_file++;
                    $display("ERROR: malformed expect line in pattern file");
                end
            end
            "V": begin
                n_args = $sscanf(cmd.substr(1, cmd.len() - 1), "%h %d", arg_a, arg_b);
                if (n_args == 2) begin
                    for (idx = 0; idx < arg_b; idx++) begin
                        drive_byte(arg_a[7:0], 1'b1);
                    end
                end else begin
                    err_file++;
                    $display("ERROR: malformed valid-byte line in pattern file");
                end
            end
            "I": begin
                n_args = $sscanf(cmd.substr(1, cmd.len() - 1), "%d", arg_a);
                if (n_args == 1) begin
                    repeat (arg_a) drive_idle();
                end else begin
                    err_file++;
                    $display("ERROR: malformed idle line in pattern file");
                end
            end
            "W": begin
                // End of block, random spacing to the next one
                drain_expected();
                rnd = $urandom % 32'd8;
                repeat (SETTLE_CYCLES + rnd) drive_idle();
            end
            "#", " ", "\n", "\r": begin
                // Comment or blank line
            end
            default: begin
                err_file++;
                $display("ERROR: unknown command '%s' in pattern file", cmd);
            end
        endcase
    endtask

    // ------------------------------------------------------------
    // Output monitor, sampled mid-cycle
    // ------------------------------------------------------------

    always @(negedge clk) begin
        if (rst_n) begin
            if (pkt_valid) begin
                if (exp_hdr.size() == 0) begin
                    err_pulse++;
                    $display("ERROR: pkt_valid pulse with no packet expected at %0t", $time);
                end else begin
                    hdr_e = exp_hdr.pop_front();
                    len_e = exp_len.pop_front();
                    checked++;
                    if (dout !== hdr_e) begin
                        err_value++;
                        $display("FAILED dout: expected %02h, got %02h", hdr_e, dout);
                    end
                    if (pkt_len !== len_e) begin
                        err_value++;
                        $display("FAILED pkt_len: expected %02h, got %02h", len_e, pkt_len);
                    end
                end
                held_dout = dout;
                held_len  = pkt_len;
            end else begin
                // Outputs must not move between pulses
                if (dout !== held_dout) begin
                    err_value++;
                    $display("FAILED dout: held %02h, got %02h", held_dout, dout);
                end
                if (pkt_len !== held_len) begin
                    err_value++;
                    $display("FAILED pkt_len: held %02h, got %02h", held_len, pkt_len);
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        int          fd;
        int          rc;
        int          total;
        string       cmd;
        void'($urandom(32'haa359730));
        din         = '0;
        din_valid   = 1'b0;
        rst_n       = 1'b0;
        err_value   = 0;
        err_pulse   = 0;
        checked     = 0;
        err_timeout = 0;
        err_file    = 0;
        err_left    = 0;
        held_dout   = '0;
        held_len    = '0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            err_file++;
            $display("ERROR: could not open pattern file %s", PATTERN_FILE);
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(cmd, fd);
                if (rc > 0) begin
                    run_command(cmd);
                end
            end
            $fclose(fd);
        end

        // Let any late pulse show up before the final count
        repeat (SETTLE_CYCLES) drive_idle();
        if (exp_hdr.size() != 0) begin
            err_left = exp_hdr.size();
            $display("ERROR: %0d expected packets were never reported", err_left);
        end

        total = err_value + err_pulse + err_timeout + err_file + err_left;
        $display("Checked %0d, errors: value %0d, pulse %0d, timeout %0d, file %0d, missing %0d",
                 checked, err_value, err_pulse, err_timeout, err_file, err_left);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* bench/packet_buffer_props.sv */
//------------------------------------------------------------
// Bound checks on the framer FSM strobes and capture outputs
// Bound twice, signals a target lacks are tied off in its bind
//------------------------------------------------------------
`timescale 1ns/1ns

module packet_buffer_props import pkt_framer_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input framer_state_t state,
    input logic          hdr_load,
    input logic          pkt_end,
    input logic          pkt_valid,
    input byte_t         dout,
    input len_t          pkt_len
);

    // Report pulse is one cycle wide
    pulse_single_a: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_valid |=> !pkt_valid)
        else $error("pkt_valid high for two cycles in a row");

    // Registered packet end follows a BODY cycle and leaves the FSM idle
    end_in_body_a: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_end |-> ($past(state) == BODY && state == IDLE))
        else $error("pkt_end raised outside BODY");

    // Registered header load follows an ARMED cycle and moves on to BODY
    hdr_in_armed_a: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_load |-> ($past(state) == ARMED && state == BODY))
        else $error("hdr_load raised outside ARMED");

    // Outputs cleared one edge into reset
    reset_clear_a: assert property (@(posedge clk)
        !rst_n |=> (!pkt_valid && dout == 8'h00 && pkt_len == 8'h00))
        else $error("outputs not cleared during reset");

endmodule

bind pkt_framer_fsm packet_buffer_props fsm_props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .hdr_load  (ctrl.hdr_load),
    .pkt_end   (ctrl.pkt_end),
    .pkt_valid (1'b0),
    .dout      (8'h00),
    .pkt_len   (8'h00)
);

bind pkt_capture packet_buffer_props cap_props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (IDLE),
    .hdr_load  (1'b0),
    .pkt_end   (1'b0),
    .pkt_valid (pkt_valid),
    .dout      (dout),
    .pkt_len   (pkt_len)
);

/* rtl/packet_buffer_top.sv */
//------------------------------------------------------------
// Byte-stream framer top, no back-pressure
// pkt_valid comes 4 clocks after the gap that ends a packet
// Every valid byte on din is consumed
//------------------------------------------------------------
`timescale 1ns/1ns

module packet_buffer_top import pkt_framer_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t din,
    input  logic  din_valid,
    output byte_t dout,
    output len_t  pkt_len,
    output logic  pkt_valid
);

    // Aligned detector outputs
    byte_t byte_q;
    logic  valid_q;
    logic  delim_q;

    // FSM to capture strobes
    pkt_ctrl_if ctrl_if ();

    // ------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------

    delim_detect u_delim_detect (
        .clk       (clk),
        .rst_n     (rst_n),
        .din       (din),
        .din_valid (din_valid),
        .byte_q    (byte_q),
        .valid_q   (valid_q),
        .delim_q   (delim_q)
    );

    // ------------------------------------------------------------
    // Framing
    // ------------------------------------------------------------

    pkt_framer_fsm u_pkt_framer_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .byte_q  (byte_q),
        .valid_q (valid_q),
        .delim_q (delim_q),
        .ctrl    (ctrl_if.fsm)
    );

    // ------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------

    pkt_capture u_pkt_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl_if.cap),
        .dout      (dout),
        .pkt_len   (pkt_len),
        .pkt_valid (pkt_valid)
    );

endmodule

/* rtl/pkt_capture.sv */
//------------------------------------------------------------
// Header and length capture, pkt_valid 1 clock after pkt_end
// dout and pkt_len hold until the next packet ends
// Length counts header plus body, saturating at LEN_MAX
//------------------------------------------------------------
`timescale 1ns/1ns

module pkt_capture import pkt_framer_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    pkt_ctrl_if.cap     ctrl,
    output byte_t       dout,
    output len_t        pkt_len,
    output logic        pkt_valid
);

    // ------------------------------------------------------------
    // Working registers for the packet in progress
    // ------------------------------------------------------------

    byte_t hdr_r;
    len_t  len_r;

    // Header only changes on hdr_load
    always_ff @(posedge clk) begin
        if (ctrl.hdr_load) begin
            hdr_r <= ctrl.data;
        end
    end

    // Count restarts at 1 for the header byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_r <= '0;
        end else if (ctrl.hdr_load) begin
            len_r <= 8'd1;
        end else if (ctrl.count_en && (len_r != LEN_MAX)) begin
            len_r <= len_r + 8'd1;
        end
    end

    // ------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------

    // Copied only at packet end, so counting never disturbs them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout      <= '0;
            pkt_len   <= '0;
            pkt_valid <= 1'b0;
        end else begin
            // Single-cycle pulse
            pkt_valid <= ctrl.pkt_end;
            if (ctrl.pkt_end) begin
                dout    <= hdr_r;
                pkt_len <= len_r;
            end
        end
    end

endmodule

/* rtl/pkt_framer_fsm.sv */
//------------------------------------------------------------
// Framing FSM, outputs registered (1 clock after input)
// A gap between delimiter and header is waited out forever
// Inside a packet the delimiter value is plain data
//------------------------------------------------------------
`timescale 1ns/1ns

module pkt_framer_fsm import pkt_framer_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  byte_t       byte_q,
    input  logic        valid_q,
    input  logic        delim_q,
    pkt_ctrl_if.fsm     ctrl
);

    // ------------------------------------------------------------
    // State and next-cycle values
    // ------------------------------------------------------------

    framer_state_t state;
    framer_state_t state_d;

    logic hdr_load_d;
    logic count_en_d;
    logic pkt_end_d;

    // ------------------------------------------------------------
    // Next-state and strobe decode
    // ------------------------------------------------------------

    always_comb begin
        // Strobes default low, state holds
        state_d    = state;
        hdr_load_d = 1'b0;
        count_en_d = 1'b0;
        pkt_end_d  = 1'b0;

        case (state)
            IDLE: begin
                // Non-delimiter bytes are dropped here
                if (delim_q) begin
                    state_d = ARMED;
                end
            end

            ARMED: begin
                // First valid byte is the header, even if it is FF
                if (valid_q) begin
                    hdr_load_d = 1'b1;
                    state_d    = BODY;
                end
            end

            BODY: begin
                if (valid_q) begin
                    count_en_d = 1'b1;
                end else begin
                    // First gap closes the packet
                    pkt_end_d = 1'b1;
                    state_d   = IDLE;
                end
            end

            // Recover from an illegal encoding
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            ctrl.hdr_load <= 1'b0;
            ctrl.count_en <= 1'b0;
            ctrl.pkt_end  <= 1'b0;
        end else begin
            state         <= state_d;
            ctrl.hdr_load <= hdr_load_d;
            ctrl.count_en <= count_en_d;
            ctrl.pkt_end  <= pkt_end_d;
        end
    end

    // Data byte travels beside the strobes
    always_ff @(posedge clk) begin
        ctrl.data <= byte_q;
    end

endmodule

/* rtl/delim_detect.sv */
//------------------------------------------------------------
// Two-stage input pipeline with delimiter compare
// Fixed latency of 2 clocks, no back-pressure
// delim_q is only ever high together with valid_q
//------------------------------------------------------------
`timescale 1ns/1ns

module delim_detect import pkt_framer_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t din,
    input  logic  din_valid,
    output byte_t byte_q,
    output logic  valid_q,
    output logic  delim_q
);

    // ------------------------------------------------------------
    // Stage 1 registers
    // ------------------------------------------------------------

    byte_t byte_s1;
    logic  valid_s1;

    // Stage 1 valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= din_valid;
        end
    end

    // Stage 1 byte
    always_ff @(posedge clk) begin
        byte_s1 <= din;
    end

    // ------------------------------------------------------------
    // Stage 2, compare and align
    // ------------------------------------------------------------

    // Flag is qualified by the valid bit before it is registered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            delim_q <= 1'b0;
        end else begin
            valid_q <= valid_s1;
            delim_q <= valid_s1 && (byte_s1 == DELIMITER);
        end
    end

    // Byte follows the flag so all three stay in step
    always_ff @(posedge clk) begin
        byte_q <= byte_s1;
    end

endmodule

/* rtl/pkt_ctrl_if.sv */
//------------------------------------------------------------
// FSM to capture link, plain strobes sampled every clock
// No handshake, the receiver must accept every strobe
//------------------------------------------------------------
`timescale 1ns/1ns

interface pkt_ctrl_if import pkt_framer_pkg::*; ();

    // Byte aligned with the strobes below
    byte_t data;

    // Load data as header, restart the count at 1
    logic hdr_load;

    // One more body byte
    logic count_en;

    // Present the finished packet
    logic pkt_end;

    // Driver side, owned by the framing FSM
    modport fsm (
        output data,
        output hdr_load,
        output count_en,
        output pkt_end
    );

    // Receiver side, the capture stage
    modport cap (
        input data,
        input hdr_load,
        input count_en,
        input pkt_end
    );

endinterface

/* rtl/pkt_framer_pkg.sv */
//------------------------------------------------------------
// Shared types and constants for the byte-stream framer
// Lengths are 8 bits wide and saturate at LEN_MAX
//------------------------------------------------------------

package pkt_framer_pkg;

    // ------------------------------------------------------------
    // Data widths
    // ------------------------------------------------------------

    // One byte of the incoming stream
    typedef logic [7:0] byte_t;

    // Packet length, header plus body bytes
    typedef logic [7:0] len_t;

    // ------------------------------------------------------------
    // Constants
    // ------------------------------------------------------------

    // Byte value that opens a packet when no packet is open
    localparam byte_t DELIMITER = 8'hFF;

    // Length counter stops here
    localparam len_t LEN_MAX = 8'd255;

    // ------------------------------------------------------------
    // Framing FSM states
    // ------------------------------------------------------------

    // IDLE  : hunting for a delimiter
    // ARMED : delimiter seen, next valid byte is the header
    // BODY  : counting body bytes until the first gap
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ARMED = 2'd1,
        BODY  = 2'd2
    } framer_state_t;

endpackage
